// ==== common/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width
`define CORE_XLEN 32

// General register file
`define CORE_REG_ADDR_W 5
`define CORE_REG_COUNT 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0040_0000

`endif

// ==== common/core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LB,
        MEM_LBU,
        MEM_SW,
        MEM_SB
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_MUL
    } wb_src_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } if_id_t;

    // All-zero value is a bubble
    typedef struct packed {
        alu_op_e                     alu_op;
        logic [`CORE_XLEN-1:0]       opr1;
        logic [`CORE_XLEN-1:0]       opr2;
        logic [`CORE_REG_ADDR_W-1:0] waddr;
        logic                        we;
        wb_src_e                     wb_src;
        mem_op_e                     mem_op;
        logic [1:0]                  addr_lo;
    } id_ex_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]       result;
        logic [`CORE_REG_ADDR_W-1:0] waddr;
        logic                        we;
        logic                        is_mul;
    } ex_mem_t;

endpackage

// ==== common/bypass_if.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

// Register write still in flight in one pipeline stage
interface bypass_if;

    logic                        we;
    logic [`CORE_REG_ADDR_W-1:0] waddr;
    logic [`CORE_XLEN-1:0]       wdata;
    // Low while wdata is not yet computed
    logic                        ready;

    modport source (
        output we, waddr, wdata, ready
    );

    modport sink (
        input we, waddr, wdata, ready
    );

endinterface

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_unit import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_stall,
    input  logic                  i_branch_taken,
    input  logic [`CORE_XLEN-1:0] i_branch_target,
    output logic [`CORE_XLEN-1:0] o_imem_raddr,
    input  logic [`CORE_XLEN-1:0] i_imem_rdata,
    output if_id_t                o_if_id
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] pc_next;

    // Taken branch in ID skips past the delay slot being fetched now
    assign pc_next = i_branch_taken ? i_branch_target : pc_q + `CORE_XLEN'(4);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q    <= `CORE_RESET_PC;
            o_if_id <= '0;
        end else if (!i_stall) begin
            pc_q          <= pc_next;
            o_if_id.pc    <= pc_q;
            o_if_id.instr <= i_imem_rdata;
        end
    end

    assign o_imem_raddr = pc_q;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        pc_q[1:0] == 2'b00
    ) else $error("fetch address is not word-aligned");

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic [`CORE_REG_ADDR_W-1:0] i_raddr1,
    input  logic [`CORE_REG_ADDR_W-1:0] i_raddr2,
    output logic [`CORE_XLEN-1:0]       o_rdata1,
    output logic [`CORE_XLEN-1:0]       o_rdata2,
    bypass_if.sink                      i_wr
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            regs <= '{default: '0};
        end else if (i_wr.we && (i_wr.waddr != '0)) begin
            regs[i_wr.waddr] <= i_wr.wdata;
        end
    end

    // r0 is hardwired to zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module instr_decoder import core_pkg::*; (
    input  if_id_t                i_if_id,
    input  logic [`CORE_XLEN-1:0] i_rs_val,
    input  logic [`CORE_XLEN-1:0] i_rt_val,
    input  logic                  i_stall,
    output id_ex_t                o_id_ex,
    output logic                  o_branch_taken,
    output logic [`CORE_XLEN-1:0] o_branch_target,
    output logic [`CORE_XLEN-1:0] o_dmem_addr,
    output logic [`CORE_XLEN-1:0] o_dmem_wdata,
    output logic                  o_dmem_we,
    output logic [3:0]            o_dmem_sel
);

    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_LB       = 6'h20;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_LBU      = 6'h24;
    localparam logic [5:0] OP_SB       = 6'h28;
    localparam logic [5:0] OP_SW       = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_MUL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    logic [5:0]                  opcode;
    logic [5:0]                  funct;
    logic [`CORE_REG_ADDR_W-1:0] rt;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [`CORE_XLEN-1:0]       shamt_ext;
    logic [`CORE_XLEN-1:0]       imm_sext;
    logic [`CORE_XLEN-1:0]       imm_zext;
    logic [`CORE_XLEN-1:0]       mem_addr;
    logic                        writes_reg;

    assign opcode    = i_if_id.instr[31:26];
    assign funct     = i_if_id.instr[5:0];
    assign rt        = i_if_id.instr[20:16];
    assign rd        = i_if_id.instr[15:11];
    assign shamt_ext = {{(`CORE_XLEN-5){1'b0}}, i_if_id.instr[10:6]};
    assign imm_sext  = {{(`CORE_XLEN-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};
    assign imm_zext  = {{(`CORE_XLEN-16){1'b0}}, i_if_id.instr[15:0]};

    always_comb begin
        o_id_ex         = '0;
        o_id_ex.alu_op  = ALU_PASS;
        o_id_ex.opr1    = i_rs_val;
        o_id_ex.opr2    = i_rt_val;
        o_id_ex.waddr   = rt;
        o_id_ex.wb_src  = WB_ALU;
        o_id_ex.mem_op  = MEM_NONE;
        o_id_ex.addr_lo = mem_addr[1:0];
        writes_reg      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                o_id_ex.waddr = rd;
                writes_reg    = 1'b1;
                case (funct)
                    FN_ADDU: o_id_ex.alu_op = ALU_ADD;
                    FN_SUBU: o_id_ex.alu_op = ALU_SUB;
                    FN_AND:  o_id_ex.alu_op = ALU_AND;
                    FN_OR:   o_id_ex.alu_op = ALU_OR;
                    FN_XOR:  o_id_ex.alu_op = ALU_XOR;
                    FN_SLT:  o_id_ex.alu_op = ALU_SLT;
                    FN_SLL: begin
                        o_id_ex.alu_op = ALU_SLL;
                        o_id_ex.opr1   = shamt_ext;
                    end
                    default: writes_reg = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                o_id_ex.waddr  = rd;
                o_id_ex.wb_src = WB_MUL;
                writes_reg     = (funct == FN_MUL);
            end
            OP_ADDIU: begin
                o_id_ex.alu_op = ALU_ADD;
                o_id_ex.opr2   = imm_sext;
                writes_reg     = 1'b1;
            end
            OP_ORI: begin
                o_id_ex.alu_op = ALU_OR;
                o_id_ex.opr2   = imm_zext;
                writes_reg     = 1'b1;
            end
            OP_LUI: begin
                o_id_ex.alu_op = ALU_LUI;
                o_id_ex.opr2   = imm_zext;
                writes_reg     = 1'b1;
            end
            OP_LW, OP_LB, OP_LBU: begin
                o_id_ex.wb_src = WB_LOAD;
                o_id_ex.mem_op = (opcode == OP_LW) ? MEM_LW :
                                 (opcode == OP_LB) ? MEM_LB : MEM_LBU;
                writes_reg     = 1'b1;
            end
            OP_SW:   o_id_ex.mem_op = MEM_SW;
            OP_SB:   o_id_ex.mem_op = MEM_SB;
            default: writes_reg = 1'b0;
        endcase
        // Writes to r0 are dropped here so they are never forwarded
        o_id_ex.we = writes_reg && (o_id_ex.waddr != '0);
    end

    // Branches compare the bypassed operands
    assign o_branch_taken = ((opcode == OP_BEQ) && (i_rs_val == i_rt_val))
                         || ((opcode == OP_BNE) && (i_rs_val != i_rt_val));
    assign o_branch_target = i_if_id.pc + `CORE_XLEN'(4)
                           + {imm_sext[`CORE_XLEN-3:0], 2'b00};

    assign mem_addr     = i_rs_val + imm_sext;
    assign o_dmem_addr  = {mem_addr[`CORE_XLEN-1:2], 2'b00};
    assign o_dmem_wdata = (o_id_ex.mem_op == MEM_SB) ? {4{i_rt_val[7:0]}} : i_rt_val;
    assign o_dmem_we    = ((o_id_ex.mem_op == MEM_SW) || (o_id_ex.mem_op == MEM_SB))
                       && !i_stall;

    always_comb begin
        case (o_id_ex.mem_op)
            MEM_LW, MEM_SW:          o_dmem_sel = 4'b1111;
            MEM_LB, MEM_LBU, MEM_SB: o_dmem_sel = 4'b0001 << mem_addr[1:0];
            default:                 o_dmem_sel = 4'b0000;
        endcase
    end

endmodule

// ==== decode/operand_bypass.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module operand_bypass (
    input  logic [`CORE_REG_ADDR_W-1:0] i_rs_addr,
    input  logic [`CORE_REG_ADDR_W-1:0] i_rt_addr,
    input  logic [`CORE_XLEN-1:0]       i_rs_rf,
    input  logic [`CORE_XLEN-1:0]       i_rt_rf,
    bypass_if.sink                      i_exe,
    bypass_if.sink                      i_mem,
    output logic [`CORE_XLEN-1:0]       o_rs_val,
    output logic [`CORE_XLEN-1:0]       o_rt_val,
    output logic                        o_stall
);

    logic rs_exe_hit;
    logic rs_mem_hit;
    logic rt_exe_hit;
    logic rt_mem_hit;

    assign rs_exe_hit = i_exe.we && (i_exe.waddr == i_rs_addr) && (i_rs_addr != '0);
    assign rs_mem_hit = i_mem.we && (i_mem.waddr == i_rs_addr) && (i_rs_addr != '0);
    assign rt_exe_hit = i_exe.we && (i_exe.waddr == i_rt_addr) && (i_rt_addr != '0);
    assign rt_mem_hit = i_mem.we && (i_mem.waddr == i_rt_addr) && (i_rt_addr != '0);

    // Youngest producer wins
    assign o_rs_val = rs_exe_hit ? i_exe.wdata : (rs_mem_hit ? i_mem.wdata : i_rs_rf);
    assign o_rt_val = rt_exe_hit ? i_exe.wdata : (rt_mem_hit ? i_mem.wdata : i_rt_rf);

    // Wait on a producer whose result is still being computed
    assign o_stall = ((rs_exe_hit || rt_exe_hit) && !i_exe.ready)
                  || (rs_mem_hit && !rs_exe_hit && !i_mem.ready)
                  || (rt_mem_hit && !rt_exe_hit && !i_mem.ready);

endmodule

// ==== execute/mult_pipe.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module mult_pipe (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic [`CORE_XLEN-1:0] i_a,
    input  logic [`CORE_XLEN-1:0] i_b,
    output logic [`CORE_XLEN-1:0] o_product_lo
);

    localparam int LANES = `CORE_XLEN / 8;

    logic [`CORE_XLEN-1:0] pp_d [LANES];
    logic [`CORE_XLEN-1:0] pp_q [LANES];

    // One partial product per byte of i_b, low word only
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            pp_d[k] = i_a * {{(`CORE_XLEN-8){1'b0}}, i_b[8*k +: 8]};
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pp_q <= '{default: '0};
        end else begin
            pp_q <= pp_d;
        end
    end

    always_comb begin
        o_product_lo = '0;
        for (int k = 0; k < LANES; k++) begin
            o_product_lo = o_product_lo + (pp_q[k] << (8 * k));
        end
    end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  id_ex_t                i_id_ex,
    input  logic                  i_stall,
    input  logic [`CORE_XLEN-1:0] i_dmem_rdata,
    bypass_if.source              o_exe,
    bypass_if.source              o_mem
);

    id_ex_t                ex_q;
    ex_mem_t               mem_q;
    logic [`CORE_XLEN-1:0] alu_result;
    logic [7:0]            load_byte;
    logic [`CORE_XLEN-1:0] load_data;
    logic [`CORE_XLEN-1:0] exe_wdata;
    logic [`CORE_XLEN-1:0] mul_lo;

    // ID/EXE, bubble while ID waits on a multiply
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_q <= '0;
        end else if (i_stall) begin
            ex_q <= '0;
        end else begin
            ex_q <= i_id_ex;
        end
    end

    always_comb begin
        case (ex_q.alu_op)
            ALU_ADD: alu_result = ex_q.opr1 + ex_q.opr2;
            ALU_SUB: alu_result = ex_q.opr1 - ex_q.opr2;
            ALU_AND: alu_result = ex_q.opr1 & ex_q.opr2;
            ALU_OR:  alu_result = ex_q.opr1 | ex_q.opr2;
            ALU_XOR: alu_result = ex_q.opr1 ^ ex_q.opr2;
            ALU_SLT: alu_result = {{(`CORE_XLEN-1){1'b0}},
                                   $signed(ex_q.opr1) < $signed(ex_q.opr2)};
            ALU_SLL: alu_result = ex_q.opr2 << ex_q.opr1[4:0];
            ALU_LUI: alu_result = {ex_q.opr2[15:0], 16'h0000};
            default: alu_result = ex_q.opr2;
        endcase
    end

    // Load data arrives this cycle for the request issued from ID
    assign load_byte = i_dmem_rdata[8*ex_q.addr_lo +: 8];

    always_comb begin
        case (ex_q.mem_op)
            MEM_LB:  load_data = {{(`CORE_XLEN-8){load_byte[7]}}, load_byte};
            MEM_LBU: load_data = {{(`CORE_XLEN-8){1'b0}}, load_byte};
            default: load_data = i_dmem_rdata;
        endcase
    end

    assign exe_wdata = (ex_q.wb_src == WB_LOAD) ? load_data : alu_result;

    mult_pipe u_mult (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_a          (ex_q.opr1),
        .i_b          (ex_q.opr2),
        .o_product_lo (mul_lo)
    );

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_q <= '0;
        end else begin
            mem_q.result <= exe_wdata;
            mem_q.waddr  <= ex_q.waddr;
            mem_q.we     <= ex_q.we;
            mem_q.is_mul <= (ex_q.wb_src == WB_MUL);
        end
    end

    assign o_exe.we    = ex_q.we;
    assign o_exe.waddr = ex_q.waddr;
    assign o_exe.wdata = exe_wdata;
    assign o_exe.ready = (ex_q.wb_src != WB_MUL);

    // Product sum completes in MEM
    assign o_mem.we    = mem_q.we;
    assign o_mem.waddr = mem_q.waddr;
    assign o_mem.wdata = mem_q.is_mul ? mul_lo : mem_q.result;
    assign o_mem.ready = 1'b1;

    a_load_dest: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (ex_q.we && (ex_q.wb_src == WB_LOAD)) |-> (ex_q.waddr != '0)
    ) else $error("load writes r0 with we set");

    // The bubble moves the multiply to MEM, where it no longer blocks ID
    a_stall_single: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_stall |=> !i_stall
    ) else $error("stall held for more than one cycle");

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  i_arst_n,
    output logic [`CORE_XLEN-1:0] o_imem_raddr,
    input  logic [`CORE_XLEN-1:0] i_imem_rdata,
    output logic [`CORE_XLEN-1:0] o_dmem_addr,
    output logic [`CORE_XLEN-1:0] o_dmem_wdata,
    output logic                  o_dmem_we,
    output logic [3:0]            o_dmem_sel,
    input  logic [`CORE_XLEN-1:0] i_dmem_rdata
);

    if_id_t                if_id;
    id_ex_t                id_ex;
    logic                  stall;
    logic                  branch_taken;
    logic [`CORE_XLEN-1:0] branch_target;
    logic [`CORE_XLEN-1:0] rs_rf;
    logic [`CORE_XLEN-1:0] rt_rf;
    logic [`CORE_XLEN-1:0] rs_val;
    logic [`CORE_XLEN-1:0] rt_val;

    bypass_if u_exe_byp ();
    bypass_if u_mem_byp ();

    fetch_unit u_fetch (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_imem_raddr    (o_imem_raddr),
        .i_imem_rdata    (i_imem_rdata),
        .o_if_id         (if_id)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_raddr1 (if_id.instr[25:21]),
        .i_raddr2 (if_id.instr[20:16]),
        .o_rdata1 (rs_rf),
        .o_rdata2 (rt_rf),
        .i_wr     (u_mem_byp)
    );

    operand_bypass u_bypass (
        .i_rs_addr (if_id.instr[25:21]),
        .i_rt_addr (if_id.instr[20:16]),
        .i_rs_rf   (rs_rf),
        .i_rt_rf   (rt_rf),
        .i_exe     (u_exe_byp),
        .i_mem     (u_mem_byp),
        .o_rs_val  (rs_val),
        .o_rt_val  (rt_val),
        .o_stall   (stall)
    );

    instr_decoder u_decoder (
        .i_if_id         (if_id),
        .i_rs_val        (rs_val),
        .i_rt_val        (rt_val),
        .i_stall         (stall),
        .o_id_ex         (id_ex),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_wdata    (o_dmem_wdata),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_sel      (o_dmem_sel)
    );

    execute_stage u_execute (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_id_ex      (id_ex),
        .i_stall      (stall),
        .i_dmem_rdata (i_dmem_rdata),
        .o_exe        (u_exe_byp),
        .o_mem        (u_mem_byp)
    );

endmodule

// ==== test/tb_core.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;

    localparam int NT = 4;
    localparam int PW = 32;
    localparam int DW = 32;
    localparam int ES = 16;
    localparam int STORE_TIMEOUT = 200;
    localparam logic [31:0] DBASE = `CORE_RESET_PC + 32'h100;

    // MIPS32 encodings
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_LB       = 6'h20;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_LBU      = 6'h24;
    localparam logic [5:0] OP_SB       = 6'h28;
    localparam logic [5:0] OP_SW       = 6'h2b;
    localparam logic [5:0] FN_SLL      = 6'h00;
    localparam logic [5:0] FN_MUL      = 6'h02;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_SLT      = 6'h2a;

    logic        clk;
    logic        i_arst_n;
    logic [31:0] o_imem_raddr;
    logic [31:0] i_imem_rdata;
    logic [31:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic        o_dmem_we;
    logic [3:0]  o_dmem_sel;
    logic [31:0] i_dmem_rdata;

    // Test table
    string       test_name [NT];
    logic [31:0] prog [NT][PW];
    logic [31:0] data_init [NT][DW];
    logic [31:0] exp_addr [NT][ES];
    logic [3:0]  exp_sel [NT][ES];
    logic [31:0] exp_data [NT][ES];
    int          prog_len [NT];
    int          exp_len [NT];

    logic [31:0] rom [128];
    logic [31:0] ram [128];
    logic [31:0] req_addr;
    logic [31:0] seen_addr [$];
    logic [3:0]  seen_sel [$];
    logic [31:0] seen_data [$];
    integer      seed;
    int          error_count;
    int          tests_ok;
    int          tests_bad;

    core_top u_dut (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .o_imem_raddr (o_imem_raddr),
        .i_imem_rdata (i_imem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_sel   (o_dmem_sel),
        .i_dmem_rdata (i_dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int mem_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `CORE_RESET_PC;
        if (off >= 32'h200) return -1;
        return int'(off[8:2]);
    endfunction

    function automatic logic [31:0] read_rom(input logic [31:0] addr);
        return (mem_index(addr) < 0) ? 32'h0 : rom[mem_index(addr)];
    endfunction

    function automatic logic [31:0] read_ram(input logic [31:0] addr);
        return (mem_index(addr) < 0) ? 32'h0 : ram[mem_index(addr)];
    endfunction

    task automatic write_ram(input logic [31:0] addr, input logic [3:0] sel,
                             input logic [31:0] data);
        int idx;
        idx = mem_index(addr);
        if (idx >= 0) begin
            for (int k = 0; k < 4; k++) begin
                if (sel[k]) ram[idx][8*k +: 8] = data[8*k +: 8];
            end
        end
    endtask

    // Fetch data and load data driven on the falling edge
    always @(negedge clk) begin
        i_imem_rdata = read_rom(o_imem_raddr);
        i_dmem_rdata = read_ram(req_addr);
    end

    // Requests from ID are taken where the DUT registers them
    always @(posedge clk) begin
        req_addr = o_dmem_addr;
        if (o_dmem_we === 1'b1) begin
            seen_addr.push_back(o_dmem_addr);
            seen_sel.push_back(o_dmem_sel);
            seen_data.push_back(o_dmem_wdata);
            write_ram(o_dmem_addr, o_dmem_sel, o_dmem_wdata);
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [31:0] r_word(input logic [5:0] op, input logic [5:0] fn,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_instr(input int t, input logic [31:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic add_expected_store(input int t, input logic [31:0] off,
                                      input logic [3:0] sel, input logic [31:0] data);
        exp_addr[t][exp_len[t]] = (DBASE + off) & 32'hFFFF_FFFC;
        exp_sel[t][exp_len[t]]  = sel;
        exp_data[t][exp_len[t]] = data;
        exp_len[t]++;
    endtask

    task automatic add_word_store(input int t, input logic [4:0] rt, input logic [31:0] off,
                                  input logic [31:0] value);
        add_instr(t, i_word(OP_SW, 30, rt, off[15:0]));
        add_expected_store(t, off, 4'hF, value);
    endtask

    // r30 holds the data base address
    task automatic add_base_setup(input int t);
        add_instr(t, i_word(OP_LUI, 0, 30, DBASE[31:16]));
        add_instr(t, i_word(OP_ORI, 30, 30, DBASE[15:0]));
    endtask

    task automatic build_tests();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        logic [31:0] g;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] prod;
        logic [31:0] preset;
        logic [7:0]  lane;
        for (int t = 0; t < NT; t++) begin
            prog_len[t] = 0;
            exp_len[t]  = 0;
            for (int i = 0; i < PW; i++) prog[t][i] = 32'h0;
            for (int i = 0; i < DW; i++) data_init[t][i] = 32'h0;
            add_base_setup(t);
        end

        test_name[0] = "alu chain";
        a = 32'd5;
        b = a + 32'hFFFF_FFFD;
        c = a + b;
        d = 32'h1234_0000 | 32'h0000_5678;
        e = d - c;
        f = e & d;
        g = f | c;
        add_instr(0, i_word(OP_ADDIU, 0, 1, 16'd5));
        add_instr(0, i_word(OP_ADDIU, 1, 2, 16'hFFFD));
        add_instr(0, r_word(OP_SPECIAL, FN_ADDU, 1, 2, 3, 0));
        add_instr(0, i_word(OP_LUI, 0, 4, 16'h1234));
        add_instr(0, i_word(OP_ORI, 4, 4, 16'h5678));
        add_instr(0, r_word(OP_SPECIAL, FN_SUBU, 4, 3, 5, 0));
        add_instr(0, r_word(OP_SPECIAL, FN_AND, 5, 4, 6, 0));
        add_instr(0, r_word(OP_SPECIAL, FN_OR, 6, 3, 7, 0));
        add_instr(0, r_word(OP_SPECIAL, FN_XOR, 7, 4, 8, 0));
        add_instr(0, i_word(OP_ADDIU, 0, 11, 16'hFFFF));
        add_instr(0, r_word(OP_SPECIAL, FN_SLT, 11, 2, 9, 0));
        add_instr(0, r_word(OP_SPECIAL, FN_SLL, 0, 3, 10, 4));
        add_word_store(0, 2, 0, b);
        add_word_store(0, 3, 4, c);
        add_word_store(0, 4, 8, d);
        add_word_store(0, 5, 12, e);
        add_word_store(0, 6, 16, f);
        add_word_store(0, 7, 20, g);
        add_word_store(0, 8, 24, g ^ d);
        add_word_store(0, 9, 28, ($signed(32'hFFFF_FFFF) < $signed(b)) ? 32'd1 : 32'd0);
        add_word_store(0, 10, 32, c << 4);

        test_name[1] = "mul stall";
        ma = $random(seed);
        mb = $random(seed);
        prod = ma * mb;
        add_instr(1, i_word(OP_LUI, 0, 1, ma[31:16]));
        add_instr(1, i_word(OP_ORI, 1, 1, ma[15:0]));
        add_instr(1, i_word(OP_LUI, 0, 2, mb[31:16]));
        add_instr(1, i_word(OP_ORI, 2, 2, mb[15:0]));
        add_instr(1, r_word(OP_SPECIAL2, FN_MUL, 1, 2, 3, 0));
        add_word_store(1, 3, 0, prod);
        add_instr(1, r_word(OP_SPECIAL, FN_ADDU, 3, 3, 4, 0));
        add_word_store(1, 4, 4, prod + prod);

        test_name[2] = "loads and byte stores";
        preset = 32'h80FF_7F01;
        data_init[2][16] = preset;
        data_init[2][17] = 32'hCAFE_F00D;
        add_instr(2, i_word(OP_LW, 30, 1, 16'h0044));
        add_word_store(2, 1, 0, 32'hCAFE_F00D);
        for (int k = 0; k < 4; k++) begin
            lane = preset[8*k +: 8];
            add_instr(2, i_word(OP_LB, 30, 2, 16'h0040 + k));
            add_word_store(2, 2, 4 + 8 * k, {{24{lane[7]}}, lane});
            add_instr(2, i_word(OP_LBU, 30, 3, 16'h0040 + k));
            add_word_store(2, 3, 8 + 8 * k, {24'h0, lane});
        end
        add_instr(2, i_word(OP_ADDIU, 0, 8, 16'h01A5));
        for (int k = 0; k < 4; k++) begin
            add_instr(2, i_word(OP_SB, 30, 8, 16'h0050 + k));
            add_expected_store(2, 32'h50 + k, 4'b0001 << k, {4{8'hA5}});
        end

        // Offset 2 skips the instruction after the delay slot
        test_name[3] = "branches";
        add_instr(3, i_word(OP_ADDIU, 0, 1, 16'd3));
        add_instr(3, i_word(OP_ADDIU, 0, 2, 16'd3));
        add_instr(3, i_word(OP_BEQ, 1, 2, 16'd2));
        add_word_store(3, 1, 0, 32'd3);
        add_instr(3, i_word(OP_SW, 30, 1, 16'd4));
        add_instr(3, i_word(OP_BNE, 1, 2, 16'd2));
        add_word_store(3, 2, 8, 32'd3);
        add_word_store(3, 2, 12, 32'd3);
        add_instr(3, i_word(OP_ADDIU, 0, 3, 16'd9));
        add_instr(3, i_word(OP_BNE, 3, 1, 16'd2));
        add_word_store(3, 3, 16, 32'd9);
        add_instr(3, i_word(OP_SW, 30, 3, 16'd20));
        add_instr(3, i_word(OP_BEQ, 3, 1, 16'd1));
        add_word_store(3, 3, 24, 32'd9);
        add_word_store(3, 1, 28, 32'd3);
    endtask

    task automatic apply_reset(input int t);
        @(negedge clk);
        i_arst_n = 1'b0;
        for (int i = 0; i < 128; i++) begin
            rom[i] = (i < PW) ? prog[t][i] : 32'h0;
            ram[i] = (i >= 64 && i < 64 + DW) ? data_init[t][i - 64] : 32'h0;
        end
        req_addr = 32'h0;
        seen_addr.delete();
        seen_sel.delete();
        seen_data.delete();
        repeat (8) begin
            @(negedge clk);
            check_value("store strobe in reset", {31'h0, o_dmem_we}, 32'h0);
        end
        i_arst_n = 1'b1;
        check_value("first fetch address", o_imem_raddr, `CORE_RESET_PC);
    endtask

    task automatic run_one_test(input int t);
        int errors_before;
        int waited;
        errors_before = error_count;
        apply_reset(t);
        for (int n = 0; n < exp_len[t]; n++) begin
            waited = 0;
            while (seen_addr.size() == 0 && waited < STORE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (seen_addr.size() == 0) begin
                $display("%s: no store seen before timeout (store %0d)", test_name[t], n);
                error_count++;
                break;
            end
            check_value("store address", seen_addr.pop_front(), exp_addr[t][n]);
            check_value("store byte select", {28'h0, seen_sel.pop_front()},
                        {28'h0, exp_sel[t][n]});
            check_value("store data", seen_data.pop_front(), exp_data[t][n]);
        end
        // Window for stray stores once the program has run out
        repeat (20) @(negedge clk);
        if (seen_addr.size() != 0) begin
            $display("%s: unexpected store to address %h", test_name[t], seen_addr[0]);
            error_count++;
        end
        if (error_count == errors_before) begin
            $display("%s: ok", test_name[t]);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", test_name[t], error_count - errors_before);
            tests_bad++;
        end
    endtask

    initial begin
        i_arst_n     = 1'b0;
        i_imem_rdata = 32'h0;
        i_dmem_rdata = 32'h0;
        req_addr     = 32'h0;
        seed         = 32'h865c1af0;
        error_count  = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        build_tests();
        for (int t = 0; t < NT; t++) begin
            run_one_test(t);
        end
        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
common/core_pkg.sv
common/bypass_if.sv
hw/fetch_unit.sv
hw/reg_file.sv
decode/instr_decoder.sv
decode/operand_bypass.sv
execute/mult_pipe.sv
execute/execute_stage.sv
hw/core_top.sv
test/tb_core.sv
